//--- px_params.svh
// Build options of the state control unit, where tick counts are got cycles and must stay below 16
`ifndef PX_PARAMS_SVH
`define PX_PARAMS_SVH

// Cycles of zwzg without oken before the bus alarm fires
`define PX_ALARM_DLY_TICKS 6

// Width of the talarm pulse
`define PX_ALARM_TICKS 2

// 1 drops hlt_n on a bus fault
`define PX_STOP_ON_NOMEM 1

// 1 blocks writes to the protected low memory block
`define PX_LOW_MEM_WRITE_DENY 1

`endif

//--- px_pkg.sv
// Shared types of the state control unit and bus words keep bit 0 as the MSB like the system bus
`default_nettype none

package px_pkg;

	// One system bus word, bit 0 is MSB
	typedef logic [0:15] word_t;

	// Interrupt sequencer phases
	typedef enum logic [2:0] {
		IRQ_IDLE = 3'd0, // No interrupt cycle
		IRQ_I1   = 3'd1, // Fetch request
		IRQ_I2   = 3'd2, // Vector read
		IRQ_I3   = 3'd3, // Register store loop
		IRQ_I4   = 3'd4, // Extended store
		IRQ_I5   = 3'd5  // Final write
	} irq_phase_t;

	// Bus controller states
	typedef enum logic [1:0] {
		BUS_IDLE  = 2'd0, // No request
		BUS_WAIT  = 2'd1, // Request out, waiting for oken
		BUS_DONE  = 2'd2, // Acknowledge latched
		BUS_ALARM = 2'd3  // Timeout pulse
	} bus_state_t;

	// Timeout and alarm pulse counter
	typedef logic [3:0] alarm_cnt_t;

endpackage

`default_nettype wire

//--- px_state_reg.sv
// Every flag loads its enter strobe on the got edge and p0 comes up set after clo
`default_nettype none

module px_state_reg (
	input  wire  got,
	input  wire  clo,
	input  wire  ek1,    // Enter K1
	input  wire  ek2,    // Enter K2
	input  wire  ep0,    // Enter P0
	input  wire  sp0,    // Force P0
	input  wire  ep1,    // Enter P1
	input  wire  sp1,    // Force P1
	input  wire  ep2,
	input  wire  ep3,
	input  wire  ep4,
	input  wire  ep5,
	input  wire  ewp,
	input  wire  ewa,
	input  wire  ewe,
	input  wire  ewr,
	input  wire  ew_amp, // Enter W&
	input  wire  ewz,
	input  wire  ewx,
	input  wire  ewm,
	input  wire  eww,
	output logic k1,
	output logic k2,
	output logic p0,
	output logic p1,
	output logic p2,
	output logic p3,
	output logic p4,
	output logic p5,
	output logic wp,
	output logic wa,
	output logic we,
	output logic wr,
	output logic w_amp,  // State W&
	output logic wz,
	output logic wx,
	output logic wm,
	output logic ww
);

	always_ff @(posedge got or posedge clo) begin
		if (clo) begin
			{k1, k2, p1, p2, p3, p4, p5} <= '0;
			{wp, wa, we, wr, w_amp, wz, wx, wm, ww} <= '0;
			p0 <= 1'b1; // Machine starts in P0
		end else begin
			{k1, k2, p2, p3, p4, p5} <= {ek1, ek2, ep2, ep3, ep4, ep5};
			{wp, wa, we, wr, w_amp, wz, wx, wm, ww} <= {ewp, ewa, ewe, ewr, ew_amp, ewz, ewx, ewm, eww};
			p0 <= ep0 | sp0; // Set input wins
			p1 <= ep1 | sp1;
		end
	end

	// Reset must leave the CPU parked in P0 when clo lets go
	a_p0_after_reset: assert property (@(posedge got) $fell(clo) |-> p0)
		else $error("p0 not set after reset");

endmodule

`default_nettype wire

//--- px_irq_phase.sv
// Interrupt phases advance one per got edge and ekc_i is combinational from the current phase
`default_nettype none

module px_irq_phase (
	input  wire                got,
	input  wire                clo,
	input  wire                si1,      // Force I1
	input  wire                lip,      // LIP instruction
	input  wire                sp,       // SP instruction
	input  wire                pp,       // Interrupt accepted
	input  wire                przerw,   // Interrupt in progress
	input  wire                przerw_z, // Interrupt with vector
	input  wire                lg_0,     // Group counter at 0
	input  wire                lg_3,     // Group counter at 3
	input  wire                exr,      // Extended return
	output px_pkg::irq_phase_t phase,
	output logic               i1,
	output logic               i2,
	output logic               i3,
	output logic               i4,
	output logic               i5,
	output logic               ekc_i,    // End of cycle
	output logic               lipsp,
	output logic               zer_sp,
	output logic               arm4,
	output logic               blw_pw
);

	px_pkg::irq_phase_t phase_nx;

	always_comb begin
		phase_nx = px_pkg::IRQ_IDLE; // Drop out unless a rule holds
		case (phase)
			px_pkg::IRQ_IDLE: begin
				if (si1 || ((exr || lip) && pp))
					phase_nx = px_pkg::IRQ_I1;
				else if (sp && pp)
					phase_nx = px_pkg::IRQ_I3; // SP skips the fetch
			end
			px_pkg::IRQ_I1: begin
				if (przerw_z)
					phase_nx = px_pkg::IRQ_I2;
				else if (lip)
					phase_nx = px_pkg::IRQ_I5;
				else if (exr || przerw)
					phase_nx = px_pkg::IRQ_I3;
			end
			px_pkg::IRQ_I2: phase_nx = px_pkg::IRQ_I3;
			px_pkg::IRQ_I3: begin
				if (lg_0)
					phase_nx = px_pkg::IRQ_I4;
				else if (!(lipsp && lg_3))
					phase_nx = px_pkg::IRQ_I3; // Loop over register group
			end
			px_pkg::IRQ_I4: phase_nx = px_pkg::IRQ_I5;
			px_pkg::IRQ_I5: begin
				if (lip)
					phase_nx = px_pkg::IRQ_I3;
			end
			default: phase_nx = px_pkg::IRQ_IDLE;
		endcase
	end

	always_ff @(posedge got or posedge clo) begin
		if (clo)
			phase <= px_pkg::IRQ_IDLE;
		else
			phase <= phase_nx;
	end

	assign i1 = (phase == px_pkg::IRQ_I1); // One-hot view
	assign i2 = (phase == px_pkg::IRQ_I2);
	assign i3 = (phase == px_pkg::IRQ_I3);
	assign i4 = (phase == px_pkg::IRQ_I4);
	assign i5 = (phase == px_pkg::IRQ_I5);

	assign lipsp  = lip | sp;
	assign ekc_i  = (i3 & lipsp & lg_3) | (i5 & ~lip); // Leave via KC
	assign zer_sp = i5 & ~lip;
	assign arm4   = i1 & lip;
	assign blw_pw = i3 & przerw & lg_3 & ~przerw_z;

	// End of cycle only comes out of an active sequence
	a_ekc_not_idle: assert property (@(posedge got) disable iff (clo)
		$rose(ekc_i) |-> (phase != px_pkg::IRQ_IDLE))
		else $error("ekc_i rose in IRQ_IDLE");

endmodule

`default_nettype wire

//--- px_bus_drive.sv
// Pure decode so every enable follows the state flags in the same cycle and is zero without zwzg
`default_nettype none
`include "px_params.svh"

module px_bus_drive (
	input  wire                k1,
	input  wire                p1,
	input  wire                p5,
	input  wire                wr,
	input  wire                ww,
	input  wire                wm,
	input  wire px_pkg::irq_phase_t phase,
	input  wire                lipsp,        // LIP or SP in progress
	input  wire                sp,
	input  wire                przerw,
	input  wire                zwzg,         // Bus granted to this unit
	input  wire                q,            // User mode
	input  wire                sbar,         // System block select
	input  wire                in,
	input  wire                ou,
	input  wire                k2fetch,
	input  wire                read_fp,
	input  wire                mcl,
	input  wire                gi,
	input  wire                ir6,
	input  wire                ir7,
	input  wire                ir8,
	input  wire                ir9,
	input  wire                pufa,         // Wide or float op
	input  wire                arz,
	input  wire                exr,
	input  wire                k2_bin_store,
	output logic               need_bus,
	output logic               r,
	output logic               w,
	output logic               pn_nb,
	output logic               bp_nb,
	output logic               bar_nb,
	output logic               q_nb,
	output logic               df,
	output logic               w_dt,
	output logic               dr,
	output logic               dt_w,
	output logic               ar_ad,
	output logic               ds,
	output logic               ic_ad,
	output logic               dmcl,
	output logic               din,
	output logic               dw,
	output px_pkg::word_t      dad,
	output px_pkg::word_t      ddt
);

	wire i1        = (phase == px_pkg::IRQ_I1);
	wire i2        = (phase == px_pkg::IRQ_I2);
	wire i3        = (phase == px_pkg::IRQ_I3);
	wire i4        = (phase == px_pkg::IRQ_I4);
	wire i5        = (phase == px_pkg::IRQ_I5);
	wire inou      = in | ou;               // I/O instruction
	wire k2fbs     = k2_bin_store | k2fetch;
	wire exrprzerw = exr | przerw;
	wire i3lips    = i3 & lipsp;
	wire wmgi      = wm & gi;               // Software interrupt send
	wire to_w      = i2 | (in & wm) | k1;   // Data bus into W
	wire ad_ad     = zwzg & i4 & exr;       // Extended state word
	// Protection passes outside user block 0 or when disabled
	wire mem_ok    = arz | ~q | exrprzerw | (`PX_LOW_MEM_WRITE_DENY == 0);
	wire barnb     = (i3 & sp) | (sbar & (ww | wr))
		| (q & (wr | p1 | p5 | wm | k2fbs | ww | read_fp));

	assign r = k2fetch | p5 | i4 | i1 | i3lips | wr | p1 | read_fp; // Bus read
	assign w = i5 | (i3 & exrprzerw) | ww | k2_bin_store;           // Bus write
	assign need_bus = wm | i2 | wr | ww | read_fp | i1 | i3 | i4 | i5
		| k2fbs | p1 | p5 | k1;

	assign pn_nb  = zwzg & ~(barnb & ~wm); // Page from PN
	assign bp_nb  = zwzg & barnb & ~wm;    // Page from BP
	assign bar_nb = zwzg & barnb;
	assign q_nb   = zwzg & ~i2;
	assign df     = zwzg & to_w;
	assign w_dt   = zwzg & ((ou & wm) ^ w);
	assign dr     = zwzg & r;
	assign dt_w   = zwzg & (to_w | r);     // Direction DT to W
	assign ar_ad  = zwzg & (i3 | read_fp | wm | p5 | ww | k2fbs | (wr & ~inou));
	assign ds     = zwzg & ou & wm;
	assign ic_ad  = zwzg & (k1 | p1 | (inou & wr));
	assign dmcl   = zwzg & mcl & wm;
	assign din    = zwzg & wmgi;
	assign dw     = zwzg & w & mem_ok;

	always_comb begin
		dad     = '0;
		dad[9]  = zwzg & (i1 | i4 | i5);
		dad[10] = zwzg & (i1 | (i4 & exr) | i5);
		dad[12] = ad_ad & pufa;
		dad[13] = ad_ad & ir7;
		dad[14] = ad_ad & ir8;
		dad[15] = (zwzg & (i1 | i5)) | (ad_ad & ir9);
	end

	always_comb begin
		ddt     = '0;
		ddt[0]  = zwzg & wmgi & ir6; // Broadcast flag
		ddt[15] = zwzg & wmgi;
	end

endmodule

`default_nettype wire

//--- px_bus_ctl.sv
// Bus request and timeout run on got with oken as a plain level and no ok arrives after an alarm
`default_nettype none
`include "px_params.svh"

module px_bus_ctl (
	input  wire  got,
	input  wire  clo,
	input  wire  need_bus, // Some state wants the bus
	input  wire  zw,       // Bus grant
	input  wire  ren,      // Memory reply
	input  wire  rok,      // Reply OK
	input  wire  rpe,      // Parity error reply
	input  wire  r,
	input  wire  w,
	input  wire  stop,
	input  wire  stop_n,
	input  wire  zga,
	output logic zwzg,
	output logic zg,
	output logic ok,
	output logic oken,
	output logic talarm,
	output logic b_p0,     // No memory fault
	output logic b_parz,   // Parity fault
	output logic bod,
	output logic awaria,
	output logic hlt_n
);

	localparam px_pkg::alarm_cnt_t DLY_LAST = px_pkg::alarm_cnt_t'(`PX_ALARM_DLY_TICKS - 1);
	localparam px_pkg::alarm_cnt_t PULSE_LAST = px_pkg::alarm_cnt_t'(`PX_ALARM_TICKS - 1);

	px_pkg::bus_state_t bus_state;
	px_pkg::alarm_cnt_t alarm_cnt;
	logic               zgi;
	logic               fault;

	assign zgi    = (bus_state != px_pkg::BUS_IDLE); // Request held till ack or alarm
	assign zwzg   = zgi & zw;
	assign oken   = ren | rok;
	assign zg     = zgi | (zw & oken);
	assign ok     = (bus_state == px_pkg::BUS_DONE);
	assign talarm = (bus_state == px_pkg::BUS_ALARM);
	assign b_p0   = talarm & (r | w);            // Read or write in progress
	assign b_parz = zwzg & rpe & r;
	assign bod    = rpe | ren;
	assign fault  = b_parz | b_p0;

	always_ff @(posedge got or posedge clo) begin
		if (clo) begin
			bus_state <= px_pkg::BUS_IDLE;
			alarm_cnt <= '0;
		end else begin
			case (bus_state)
				px_pkg::BUS_IDLE: begin
					alarm_cnt <= '0;
					if (need_bus)
						bus_state <= px_pkg::BUS_WAIT;
				end
				px_pkg::BUS_WAIT: begin
					if (zwzg && oken) begin
						bus_state <= px_pkg::BUS_DONE; // Latch ack
					end else if (zwzg && alarm_cnt == DLY_LAST) begin
						bus_state <= px_pkg::BUS_ALARM;
						alarm_cnt <= '0;
					end else if (zwzg) begin
						alarm_cnt <= alarm_cnt + 1'b1; // Only granted cycles count
					end
				end
				px_pkg::BUS_DONE: bus_state <= px_pkg::BUS_IDLE; // Drop zgi after ok
				px_pkg::BUS_ALARM: begin
					if (alarm_cnt == PULSE_LAST) begin
						bus_state <= px_pkg::BUS_IDLE; // Alarm ends the wait
						alarm_cnt <= '0;
					end else begin
						alarm_cnt <= alarm_cnt + 1'b1;
					end
				end
				default: bus_state <= px_pkg::BUS_IDLE;
			endcase
		end
	end

	always_ff @(posedge got or posedge clo) begin
		if (clo) begin
			awaria <= 1'b0;
			hlt_n  <= 1'b1;
		end else begin
			if (stop)
				awaria <= 1'b0; // Operator clears
			else if (fault)
				awaria <= 1'b1;
			if (fault && `PX_STOP_ON_NOMEM != 0)
				hlt_n <= 1'b0;
			else if (stop_n && zga && zwzg)
				hlt_n <= 1'b1;
		end
	end

	// The ack latch only opens on a granted cycle
	a_ok_needs_zwzg: assert property (@(posedge got) disable iff (clo)
		$rose(ok) |-> $past(zwzg))
		else $error("ok rose without zwzg");

	a_talarm_len: assert property (@(posedge got) disable iff (clo)
		$rose(talarm) |-> talarm [*`PX_ALARM_TICKS] ##1 !talarm)
		else $error("talarm width wrong");

endmodule

`default_nettype wire

//--- px.sv
// Top of the state control unit with got as the only clock and no logic outside the four blocks
`default_nettype none

module px (
	input  wire           got,
	input  wire           clo,
	input  wire           ek1,
	input  wire           ek2,
	input  wire           ep0,
	input  wire           sp0,
	input  wire           ep1,
	input  wire           sp1,
	input  wire           ep2,
	input  wire           ep3,
	input  wire           ep4,
	input  wire           ep5,
	input  wire           ewp,
	input  wire           ewa,
	input  wire           ewe,
	input  wire           ewr,
	input  wire           ew_amp,
	input  wire           ewz,
	input  wire           ewx,
	input  wire           ewm,
	input  wire           eww,
	input  wire           si1,
	input  wire           lip,
	input  wire           sp,
	input  wire           pp,
	input  wire           przerw,
	input  wire           przerw_z,
	input  wire           lg_0,
	input  wire           lg_3,
	input  wire           exr,
	input  wire           q,
	input  wire           sbar,
	input  wire           in,
	input  wire           ou,
	input  wire           k2fetch,
	input  wire           read_fp,
	input  wire           mcl,
	input  wire           gi,
	input  wire           ir6,
	input  wire           ir7,
	input  wire           ir8,
	input  wire           ir9,
	input  wire           pufa,
	input  wire           arz,
	input  wire           k2_bin_store,
	input  wire           zw,
	input  wire           ren,
	input  wire           rok,
	input  wire           rpe,
	input  wire           stop,
	input  wire           stop_n,
	input  wire           zga,
	output wire           k1,
	output wire           k2,
	output wire           p0,
	output wire           p1,
	output wire           p2,
	output wire           p3,
	output wire           p4,
	output wire           p5,
	output wire           wp,
	output wire           wa,
	output wire           we,
	output wire           wr,
	output wire           w_amp,
	output wire           wz,
	output wire           wx,
	output wire           wm,
	output wire           ww,
	output wire           i1,
	output wire           i2,
	output wire           i3,
	output wire           i4,
	output wire           i5,
	output wire           ekc_i,
	output wire           lipsp,
	output wire           zer_sp,
	output wire           arm4,
	output wire           blw_pw,
	output wire           pn_nb,
	output wire           bp_nb,
	output wire           bar_nb,
	output wire           q_nb,
	output wire           df,
	output wire           w_dt,
	output wire           dr,
	output wire           dt_w,
	output wire           ar_ad,
	output wire           ds,
	output wire           ic_ad,
	output wire           dmcl,
	output wire           din,
	output wire           dw,
	output px_pkg::word_t dad,
	output px_pkg::word_t ddt,
	output wire           zg,
	output wire           ok,
	output wire           oken,
	output wire           talarm,
	output wire           b_p0,
	output wire           b_parz,
	output wire           bod,
	output wire           awaria,
	output wire           hlt_n
);

	px_pkg::irq_phase_t phase; // Sequencer to bus decode
	wire                zwzg;     // Grant seen by drivers
	wire                need_bus;
	wire                r;
	wire                w;

	px_state_reg u_state (
		.got(got), .clo(clo),
		.ek1(ek1), .ek2(ek2), .ep0(ep0), .sp0(sp0), .ep1(ep1), .sp1(sp1),
		.ep2(ep2), .ep3(ep3), .ep4(ep4), .ep5(ep5),
		.ewp(ewp), .ewa(ewa), .ewe(ewe), .ewr(ewr), .ew_amp(ew_amp),
		.ewz(ewz), .ewx(ewx), .ewm(ewm), .eww(eww),
		.k1(k1), .k2(k2), .p0(p0), .p1(p1), .p2(p2), .p3(p3), .p4(p4), .p5(p5),
		.wp(wp), .wa(wa), .we(we), .wr(wr), .w_amp(w_amp),
		.wz(wz), .wx(wx), .wm(wm), .ww(ww)
	);

	px_irq_phase u_irq (
		.got(got), .clo(clo),
		.si1(si1), .lip(lip), .sp(sp), .pp(pp), .przerw(przerw), .przerw_z(przerw_z),
		.lg_0(lg_0), .lg_3(lg_3), .exr(exr),
		.phase(phase),
		.i1(i1), .i2(i2), .i3(i3), .i4(i4), .i5(i5),
		.ekc_i(ekc_i), .lipsp(lipsp), .zer_sp(zer_sp), .arm4(arm4), .blw_pw(blw_pw)
	);

	px_bus_drive u_drive (
		.k1(k1), .p1(p1), .p5(p5), .wr(wr), .ww(ww), .wm(wm),
		.phase(phase), .lipsp(lipsp), .sp(sp), .przerw(przerw), .zwzg(zwzg),
		.q(q), .sbar(sbar), .in(in), .ou(ou), .k2fetch(k2fetch), .read_fp(read_fp),
		.mcl(mcl), .gi(gi), .ir6(ir6), .ir7(ir7), .ir8(ir8), .ir9(ir9),
		.pufa(pufa), .arz(arz), .exr(exr), .k2_bin_store(k2_bin_store),
		.need_bus(need_bus), .r(r), .w(w),
		.pn_nb(pn_nb), .bp_nb(bp_nb), .bar_nb(bar_nb), .q_nb(q_nb), .df(df),
		.w_dt(w_dt), .dr(dr), .dt_w(dt_w), .ar_ad(ar_ad), .ds(ds), .ic_ad(ic_ad),
		.dmcl(dmcl), .din(din), .dw(dw), .dad(dad), .ddt(ddt)
	);

	px_bus_ctl u_ctl (
		.got(got), .clo(clo),
		.need_bus(need_bus), .zw(zw), .ren(ren), .rok(rok), .rpe(rpe),
		.r(r), .w(w), .stop(stop), .stop_n(stop_n), .zga(zga),
		.zwzg(zwzg), .zg(zg), .ok(ok), .oken(oken), .talarm(talarm),
		.b_p0(b_p0), .b_parz(b_parz), .bod(bod), .awaria(awaria), .hlt_n(hlt_n)
	);

endmodule

`default_nettype wire

//--- tb_px.sv
// Needs concurrent assertions with pufa and ir7 to ir9 low and rpe or alarms only in plain WR or WW
`default_nettype none
`include "px_params.svh"

module tb_px;

	localparam int STATE_N = 200;                          // Random state entry cycles
	localparam int IRQ_N = 300;                            // Random sequencer cycles
	localparam int DRIVE_N = 200;                          // Random driver cycles
	localparam int ALARM_WAIT = `PX_ALARM_DLY_TICKS + 10;  // Bound on alarm edges
	localparam int TEST_CYCLES = 4 + STATE_N + IRQ_N + DRIVE_N + 2 * ALARM_WAIT + 60;

	logic got, clo;
	logic [16:0] ent;                                      // ek1 at bit 16 down to eww at bit 0
	logic sp0, sp1;
	logic si1, lip, sp, pp, przerw, przerw_z, lg_0, lg_3, exr;
	logic q, sbar, in, ou, k2fetch, read_fp, mcl, gi, ir6, ir7, ir8, ir9;
	logic pufa, arz, k2_bin_store;
	logic zw, ren, rok, rpe, stop, stop_n, zga;

	wire k1, k2, p0, p1, p2, p3, p4, p5;
	wire wp, wa, we, wr, w_amp, wz, wx, wm, ww;
	wire i1, i2, i3, i4, i5, ekc_i, lipsp, zer_sp, arm4, blw_pw;
	wire pn_nb, bp_nb, bar_nb, q_nb, df, w_dt, dr, dt_w, ar_ad, ds, ic_ad, dmcl, din, dw;
	wire [0:15] dad, ddt;
	wire zg, ok, oken, talarm, b_p0, b_parz, bod, awaria, hlt_n;

	wire [16:0] flags = {k1, k2, p0, p1, p2, p3, p4, p5, wp, wa, we, wr, w_amp, wz, wx, wm, ww};
	wire [4:0]  i_vec = {i1, i2, i3, i4, i5};
	wire [13:0] drv = {pn_nb, bp_nb, bar_nb, q_nb, df, w_dt, dr, dt_w, ar_ad, ds, ic_ad,
		dmcl, din, dw};

	logic [15:0] lfsr;
	int          errors;

	logic [16:0] flags_m;                                  // Expected flags
	int          ph_m;                                     // Expected phase with 0 as idle
	logic        req_m, ack_m, alarm_m;                    // Expected bus request, ok, talarm
	int          cnt_m;
	logic        awaria_m, hlt_m;

	wire zwzg_m = req_m & zw;
	wire oken_m = ren | rok;
	wire xfer_m = flags_m[0] | flags_m[5];                 // WW or WR in progress
	wire bp0_m = alarm_m & xfer_m;
	wire parz_m = zwzg_m & rpe & flags_m[5];               // Parity only in a plain read
	wire fault_m = bp0_m | parz_m;
	wire need_m = flags_m[16] | flags_m[13] | flags_m[9] | flags_m[5] | flags_m[1]
		| flags_m[0] | (ph_m != 0) | read_fp | k2fetch | k2_bin_store;
	wire ekc_m = ((ph_m == 3) & (lip | sp) & lg_3) | ((ph_m == 5) & ~lip);

	px uut (
		.ek1(ent[16]), .ek2(ent[15]), .ep0(ent[14]), .ep1(ent[13]), .ep2(ent[12]),
		.ep3(ent[11]), .ep4(ent[10]), .ep5(ent[9]), .ewp(ent[8]), .ewa(ent[7]),
		.ewe(ent[6]), .ewr(ent[5]), .ew_amp(ent[4]), .ewz(ent[3]), .ewx(ent[2]),
		.ewm(ent[1]), .eww(ent[0]),
		.*
	);

	always #2 got = ~got;                                  // Period 4

	always @(posedge got or posedge clo) begin
		if (clo)
			flags_m <= 17'h04000;                          // Only P0
		else
			flags_m <= ent | {2'b00, sp0, sp1, 13'd0};     // Force inputs
	end

	always @(posedge got or posedge clo) begin
		if (clo)
			ph_m <= 0;
		else
			ph_m <= irq_next(ph_m);
	end

	always @(posedge got or posedge clo) begin
		if (clo) begin
			{req_m, ack_m, alarm_m} <= 3'b000;
			cnt_m <= 0;
		end else if (alarm_m) begin
			if (cnt_m == `PX_ALARM_TICKS - 1)
				{alarm_m, req_m} <= 2'b00;                 // Alarm ends the wait
			cnt_m <= cnt_m + 1;
		end else if (ack_m) begin
			{ack_m, req_m} <= 2'b00;
		end else if (req_m && zwzg_m) begin
			if (oken_m) begin
				ack_m <= 1'b1;
			end else if (cnt_m == `PX_ALARM_DLY_TICKS - 1) begin
				alarm_m <= 1'b1;
				cnt_m <= 0;
			end else begin
				cnt_m <= cnt_m + 1;                        // Granted cycle without oken
			end
		end else if (!req_m && need_m) begin
			req_m <= 1'b1;
			cnt_m <= 0;
		end
	end

	always @(posedge got or posedge clo) begin
		if (clo) begin
			awaria_m <= 1'b0;
			hlt_m <= 1'b1;
		end else begin
			if (stop)
				awaria_m <= 1'b0;
			else if (fault_m)
				awaria_m <= 1'b1;
			if (fault_m && `PX_STOP_ON_NOMEM != 0)
				hlt_m <= 1'b0;
			else if (stop_n && zga && zwzg_m)
				hlt_m <= 1'b1;                             // Restart from the panel
		end
	end

	a_reset: assert property (@(posedge got) $fell(clo) |->
		flags == 17'h04000 && i_vec == 5'd0 && !zg && !ok && !awaria && hlt_n)
		else begin
			errors++;
			$display("Mismatch reset flags expected 04000 actual %h, i %h zg %h ok %h awaria %h hlt_n %h",
				$sampled(flags), $sampled(i_vec), $sampled(zg), $sampled(ok),
				$sampled(awaria), $sampled(hlt_n));
		end

	a_flags: assert property (@(posedge got) disable iff (clo) flags == flags_m)
		else begin
			errors++;
			$display("Mismatch flags expected %h actual %h", $sampled(flags_m), $sampled(flags));
		end

	a_phase: assert property (@(posedge got) disable iff (clo) i_vec == phase_bits(ph_m))
		else begin
			errors++;
			$display("Mismatch i1_i5 expected %h actual %h", phase_bits($sampled(ph_m)),
				$sampled(i_vec));
		end

	a_ekc: assert property (@(posedge got) disable iff (clo) ekc_i == ekc_m)
		else begin
			errors++;
			$display("Mismatch ekc_i expected %h actual %h", $sampled(ekc_m), $sampled(ekc_i));
		end

	a_gate: assert property (@(posedge got) disable iff (clo) !zwzg_m |-> drv == 14'd0)
		else begin
			errors++;
			$display("Mismatch drivers expected 0000 actual %h", $sampled(drv));
		end

	a_dad: assert property (@(posedge got) disable iff (clo) dad == dad_expect(ph_m, zwzg_m, exr))
		else begin
			errors++;
			$display("Mismatch dad expected %h actual %h",
				dad_expect($sampled(ph_m), $sampled(zwzg_m), $sampled(exr)), $sampled(dad));
		end

	a_ddt: assert property (@(posedge got) disable iff (clo)
		ddt == ddt_expect(zwzg_m & flags_m[1] & gi, ir6))
		else begin
			errors++;
			$display("Mismatch ddt expected %h actual %h",
				ddt_expect($sampled(zwzg_m & flags_m[1] & gi), $sampled(ir6)), $sampled(ddt));
		end

	a_zg: assert property (@(posedge got) disable iff (clo) zg == (req_m | (zw & oken_m)))
		else begin
			errors++;
			$display("Mismatch zg expected %h actual %h", $sampled(req_m | (zw & oken_m)),
				$sampled(zg));
		end

	a_oken: assert property (@(posedge got) disable iff (clo) oken == oken_m)
		else begin
			errors++;
			$display("Mismatch oken expected %h actual %h", $sampled(oken_m), $sampled(oken));
		end

	a_ok: assert property (@(posedge got) disable iff (clo) ok == ack_m)
		else begin
			errors++;
			$display("Mismatch ok expected %h actual %h", $sampled(ack_m), $sampled(ok));
		end

	a_talarm: assert property (@(posedge got) disable iff (clo) talarm == alarm_m)
		else begin
			errors++;
			$display("Mismatch talarm expected %h actual %h in bus state %h", $sampled(alarm_m),
				$sampled(talarm), $sampled(uut.u_ctl.bus_state));
		end

	a_b_p0: assert property (@(posedge got) disable iff (clo) b_p0 == bp0_m)
		else begin
			errors++;
			$display("Mismatch b_p0 expected %h actual %h", $sampled(bp0_m), $sampled(b_p0));
		end

	a_b_parz: assert property (@(posedge got) disable iff (clo) b_parz == parz_m)
		else begin
			errors++;
			$display("Mismatch b_parz expected %h actual %h", $sampled(parz_m), $sampled(b_parz));
		end

	a_awaria: assert property (@(posedge got) disable iff (clo) awaria == awaria_m)
		else begin
			errors++;
			$display("Mismatch awaria expected %h actual %h", $sampled(awaria_m), $sampled(awaria));
		end

	a_hlt: assert property (@(posedge got) disable iff (clo) hlt_n == hlt_m)
		else begin
			errors++;
			$display("Mismatch hlt_n expected %h actual %h", $sampled(hlt_m), $sampled(hlt_n));
		end

	// Sequencer rules with phase numbers matching I1 to I5
	function automatic int irq_next(input int ph);
		case (ph)
			0: return (si1 || ((exr || lip) && pp)) ? 1 : ((sp && pp) ? 3 : 0);
			1: return przerw_z ? 2 : (lip ? 5 : ((exr || przerw) ? 3 : 0));
			2: return 3;
			3: return lg_0 ? 4 : (((lip || sp) && lg_3) ? 0 : 3);
			4: return 5;
			5: return lip ? 3 : 0;
			default: return 0;
		endcase
	endfunction

	function automatic logic [4:0] phase_bits(input int ph);
		return (ph == 0) ? 5'b00000 : (5'b10000 >> (ph - 1));
	endfunction

	function automatic px_pkg::word_t dad_expect(input int ph, input logic grant, input logic ext);
		px_pkg::word_t v;
		v = '0;
		if (grant && (ph == 1 || ph == 5)) begin
			v[9] = 1'b1;
			v[10] = 1'b1;
			v[15] = 1'b1;
		end else if (grant && ph == 4) begin
			v[9] = 1'b1;
			v[10] = ext;                                   // Extended return only
		end
		return v;
	endfunction

	function automatic px_pkg::word_t ddt_expect(input logic send, input logic bcast);
		px_pkg::word_t v;
		v = '0;
		v[15] = send;
		v[0] = send & bcast;
		return v;
	endfunction

	// Galois LFSR with taps x^16 x^14 x^13 x^11
	function automatic logic next_bit();
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		return lfsr[0];
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], next_bit()};
		return v;
	endfunction

	task automatic clear_inputs();
		ent = '0;
		{sp0, sp1, si1, lip, sp, pp, przerw, przerw_z, lg_0, lg_3, exr} = '0;
		{q, sbar, in, ou, k2fetch, read_fp, mcl, gi, ir6, ir7, ir8, ir9} = '0;
		{pufa, arz, k2_bin_store} = '0;
		{zw, ren, rok, rpe, stop, stop_n, zga} = '0;
	endtask

	task automatic drive_irq_random();
		{si1, lip, sp, pp, przerw, przerw_z, lg_0, lg_3, exr} = 9'(rand_bits(9));
	endtask

	task automatic park_sequencer();
		{si1, lip, sp, pp, przerw, przerw_z, lg_3, exr} = '0;
		lg_0 = 1'b1;                                       // I3 leaves through I4 and I5
		repeat (6) @(negedge got);
		lg_0 = 1'b0;
	endtask

	task automatic report_test(input int num, input string name);
		$display("Test %0d %s finished, errors so far %0d", num, name, errors);
	endtask

	initial begin
		int n;
		got = 1'b0;
		clo = 1'b1;
		lfsr = 16'd40;
		errors = 0;
		clear_inputs();
		repeat (4) @(negedge got);
		clo = 1'b0;
		@(negedge got);                                    // Reset values checked on this edge
		report_test(1, "reset");

		repeat (STATE_N) begin
			ent = 17'(rand_bits(17));
			sp0 = next_bit();
			sp1 = next_bit();
			@(negedge got);
		end
		clear_inputs();
		@(negedge got);
		report_test(2, "state entry");

		repeat (IRQ_N) begin
			drive_irq_random();
			@(negedge got);
		end
		park_sequencer();
		report_test(3, "interrupt sequence");

		zw = 1'b1;
		ren = 1'b1;                                        // Every request acknowledged
		repeat (DRIVE_N) begin
			ent = 17'(rand_bits(17));
			drive_irq_random();
			{gi, ir6, read_fp, k2fetch, k2_bin_store, q, sbar, in, ou, mcl, arz} = 11'(rand_bits(11));
			@(negedge got);
		end
		ent = '0;
		{gi, ir6, read_fp, k2fetch, k2_bin_store, q, sbar, in, ou, mcl, arz} = '0;
		park_sequencer();
		zw = 1'b0;
		ren = 1'b0;
		report_test(4, "bus drivers");

		ent = 17'h00020;                                   // WR held
		zw = 1'b1;
		{stop_n, zga} = 2'b11;
		repeat (3) @(negedge got);                         // zg holds without oken
		{rok, rpe} = 2'b11;                                // Read reply with a parity error
		for (n = 0; n < 10 && ok !== 1'b1; n++)
			@(negedge got);
		if (ok !== 1'b1) begin
			errors++;
			$display("ok did not rise after rok was given");
		end
		{rok, rpe} = 2'b00;
		ent = '0;
		@(negedge got);                                    // Granted DONE cycle lifts hlt_n
		{zw, stop_n, zga} = 3'b000;
		stop = 1'b1;                                       // Clears awaria
		@(negedge got);
		stop = 1'b0;
		repeat (3) @(negedge got);
		report_test(5, "acknowledge");

		ent = 17'h00001;                                   // WW held for a write cycle
		zw = 1'b1;
		for (n = 0; n < ALARM_WAIT && talarm !== 1'b1; n++)
			@(negedge got);
		if (talarm !== 1'b1) begin
			errors++;
			$display("talarm did not rise while oken was held low");
		end
		for (n = 0; n < ALARM_WAIT && talarm !== 1'b0; n++)
			@(negedge got);
		ent = '0;
		zw = 1'b0;
		repeat (3) @(negedge got);
		stop = 1'b1;                                       // Clears awaria
		@(negedge got);
		stop = 1'b0;
		{stop_n, zga, zw, ren} = 4'b1111;                  // Granted cycle lifts hlt_n
		ent = 17'h00001;
		repeat (5) @(negedge got);
		clear_inputs();
		repeat (4) @(negedge got);
		report_test(6, "timeout");

		$display("Summary: 6 tests run, %0d errors", errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	initial begin
		#(TEST_CYCLES * 4 * 3 / 2);                        // Test length plus half
		$display("Watchdog expired before the tests finished");
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
+incdir+.
px_pkg.sv
px_state_reg.sv
px_irq_phase.sv
px_bus_drive.sv
px_bus_ctl.sv
px.sv
tb_px.sv

//--- Bender.yml
package:
  name: px

sources:
  - include_dirs:
      - .
    files:
      - px_pkg.sv
      - px_state_reg.sv
      - px_irq_phase.sv
      - px_bus_drive.sv
      - px_bus_ctl.sv
      - px.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_px.sv
